//--- dla_wrapper.f
src/dla_pkg.sv
src/apb2csb.sv
src/csb_regs.sv
src/beat_fifo.sv
src/dbb_copy_engine.sv
src/dla_wrapper.sv
test/axi_mem_model.sv
test/tb_dla_wrapper.sv

//--- test/tb_dla_wrapper.sv
module tb_dla_wrapper;

    // 81 beats at 8 cycles each, plus register traffic and polling, with headroom
    localparam int TIMEOUT_CYCLES = 4000;

    logic               core_clk;
    logic               rst_n;
    logic               dla_intr;
    logic               stall_en;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [31:0]        paddr;
    logic [31:0]        pwdata;
    dla_pkg::csb_data_t prdata;
    logic               pready;

    logic               arvalid;
    logic               arready;
    dla_pkg::dbb_id_t   arid;
    dla_pkg::dbb_len_t  arlen;
    dla_pkg::dbb_addr_t araddr;
    logic               rvalid;
    logic               rready;
    dla_pkg::dbb_id_t   rid;
    logic               rlast;
    dla_pkg::dbb_data_t rdata;
    logic               awvalid;
    logic               awready;
    dla_pkg::dbb_id_t   awid;
    dla_pkg::dbb_len_t  awlen;
    dla_pkg::dbb_addr_t awaddr;
    logic               wvalid;
    logic               wready;
    dla_pkg::dbb_data_t wdata;
    dla_pkg::dbb_strb_t wstrb;
    logic               wlast;
    logic               bvalid;
    logic               bready;
    dla_pkg::dbb_id_t   bid;

    int cycles = 0;

    dla_wrapper u_dla_wrapper (.*);

    axi_mem_model u_mem (.*);

    initial begin
        core_clk = 1'b0;
        forever #4 core_clk = ~core_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and compares
    //////////////////////////////////////////////////////////////////////

    task automatic fail_run();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    always @(posedge core_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycles);
            fail_run();
        end
    end

    task automatic check_csb_data(input string name, input dla_pkg::csb_data_t got,
                                  input dla_pkg::csb_data_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_beat(input string name, input dla_pkg::dbb_data_t got,
                              input dla_pkg::dbb_data_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_addr(input string name, input dla_pkg::dbb_addr_t got,
                              input dla_pkg::dbb_addr_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_len(input string name, input dla_pkg::dbb_len_t got,
                             input dla_pkg::dbb_len_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_id(input string name, input dla_pkg::dbb_id_t got,
                            input dla_pkg::dbb_id_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_strb(input string name, input dla_pkg::dbb_strb_t got,
                              input dla_pkg::dbb_strb_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    // Every accepted W beat carries full byte strobes
    always @(posedge core_clk) begin
        if (rst_n && wvalid && wready) begin
            check_strb("wstrb", wstrb, 8'hff);
        end
    end

    // Source memory contents as seen by the copy
    function automatic dla_pkg::dbb_data_t expected_word(input dla_pkg::dbb_addr_t a);
        return {a[31:0], a[63:32]} ^ 64'h9e37_79b9_7f4a_7c15;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // APB driver and copy helpers
    //////////////////////////////////////////////////////////////////////

    task automatic apb_write(input dla_pkg::csb_addr_t off, input dla_pkg::csb_data_t data);
        @(posedge core_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= {14'd0, off, 2'b00};
        pwdata  <= data;
        @(posedge core_clk);
        penable <= 1'b1;
        @(posedge core_clk);
        while (!pready) @(posedge core_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input dla_pkg::csb_addr_t off, output dla_pkg::csb_data_t data);
        @(posedge core_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= {14'd0, off, 2'b00};
        @(posedge core_clk);
        penable <= 1'b1;
        @(posedge core_clk);
        while (!pready) @(posedge core_clk);
        data = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic start_copy(input dla_pkg::dbb_addr_t src, input dla_pkg::dbb_addr_t dst,
                              input dla_pkg::copy_len_t len);
        apb_write(dla_pkg::REG_STATUS, 32'h2);
        apb_write(dla_pkg::REG_SRC_LO, src[31:0]);
        apb_write(dla_pkg::REG_SRC_HI, src[63:32]);
        apb_write(dla_pkg::REG_DST_LO, dst[31:0]);
        apb_write(dla_pkg::REG_DST_HI, dst[63:32]);
        apb_write(dla_pkg::REG_LEN, len);
        apb_write(dla_pkg::REG_CTRL, 32'h1);
    endtask

    task automatic wait_done(output dla_pkg::csb_data_t status);
        status = '0;
        while (!status[1]) apb_read(dla_pkg::REG_STATUS, status);
    endtask

    task automatic check_copy(input dla_pkg::dbb_addr_t src, input dla_pkg::dbb_addr_t dst,
                              input int len);
        dla_pkg::dbb_addr_t a;
        for (int i = 0; i < len; i++) begin
            a = dst + dla_pkg::dbb_addr_t'(i * 8);
            check_beat($sformatf("dst word %0d", i), u_mem.mem[a[15:3]],
                       expected_word(src + dla_pkg::dbb_addr_t'(i * 8)));
        end
    endtask

    task automatic check_burst(input int idx, input dla_pkg::dbb_addr_t addr,
                               input dla_pkg::dbb_len_t len, input dla_pkg::dbb_id_t id);
        check_addr($sformatf("awaddr[%0d]", idx), u_mem.aw_log_addr[idx], addr);
        check_len($sformatf("awlen[%0d]", idx), u_mem.aw_log_len[idx], len);
        check_id($sformatf("awid[%0d]", idx), u_mem.aw_log_id[idx], id);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_regs();
        dla_pkg::csb_data_t data;
        dla_pkg::csb_data_t vals [6] = '{32'h1234_5678, 32'h9abc_def0, 32'h0bad_f00d,
                                         32'h0000_00ff, 32'h0000_0123, 32'h0000_0001};
        check_flag("dla_intr", dla_intr, 1'b0);
        apb_read(dla_pkg::REG_STATUS, data);
        check_csb_data("STATUS", data, 32'h0);
        for (int i = 0; i < 6; i++) begin
            apb_write(dla_pkg::csb_addr_t'(i + 2), vals[i]);
        end
        for (int i = 0; i < 6; i++) begin
            apb_read(dla_pkg::csb_addr_t'(i + 2), data);
            check_csb_data($sformatf("register %0d", i + 2), data, vals[i]);
        end
        apb_read(dla_pkg::REG_CTRL, data);
        check_csb_data("CTRL", data, 32'h0);
        apb_read(16'd9, data);
        check_csb_data("unmapped offset 9", data, 32'h0);
    endtask

    task automatic test_single_burst();
        dla_pkg::csb_data_t status;
        int                 base;
        base = u_mem.aw_count;
        apb_write(dla_pkg::REG_INTR_EN, 32'h1);
        start_copy(64'h0000_0001_0000_1000, 64'h4000, 16);
        wait_done(status);
        check_csb_data("STATUS", status, 32'h2);
        check_flag("dla_intr", dla_intr, 1'b1);
        check_csb_data("burst count", dla_pkg::csb_data_t'(u_mem.aw_count - base), 32'd1);
        check_burst(base, 64'h4000, 4'd15, 8'd0);
        check_copy(64'h0000_0001_0000_1000, 64'h4000, 16);
    endtask

    task automatic test_stalled_copy();
        dla_pkg::csb_data_t status;
        int                 base;
        base = u_mem.aw_count;
        @(posedge core_clk);
        stall_en <= 1'b1;
        start_copy(64'h2000, 64'h6000, 37);
        wait_done(status);
        check_csb_data("STATUS", status, 32'h2);
        check_csb_data("burst count", dla_pkg::csb_data_t'(u_mem.aw_count - base), 32'd3);
        check_burst(base, 64'h6000, 4'd15, 8'd0);
        check_burst(base + 1, 64'h6080, 4'd15, 8'd1);
        check_burst(base + 2, 64'h6100, 4'd4, 8'd2);
        check_copy(64'h2000, 64'h6000, 37);
    endtask

    task automatic test_done_clear();
        dla_pkg::csb_data_t status;
        check_flag("dla_intr", dla_intr, 1'b1);
        apb_write(dla_pkg::REG_STATUS, 32'h2);
        @(posedge core_clk);
        check_flag("dla_intr", dla_intr, 1'b0);
        apb_write(dla_pkg::REG_INTR_EN, 32'h0);
        start_copy(64'h3000, 64'h8000, 8);
        wait_done(status);
        check_csb_data("STATUS", status, 32'h2);
        check_flag("dla_intr", dla_intr, 1'b0);
        check_copy(64'h3000, 64'h8000, 8);
    endtask

    task automatic test_start_guards();
        dla_pkg::csb_data_t status;
        int                 base;
        int                 writes;
        base   = u_mem.aw_count;
        writes = u_mem.w_count;
        apb_write(dla_pkg::REG_STATUS, 32'h2);
        apb_write(dla_pkg::REG_LEN, 32'h0);
        apb_write(dla_pkg::REG_CTRL, 32'h1);
        repeat (4) @(posedge core_clk);
        apb_read(dla_pkg::REG_STATUS, status);
        check_csb_data("STATUS after empty start", status, 32'h0);
        check_csb_data("AW count", dla_pkg::csb_data_t'(u_mem.aw_count), base);
        check_csb_data("W count", dla_pkg::csb_data_t'(u_mem.w_count), writes);

        // Restart attempt with new addresses while the copy runs
        start_copy(64'h5000, 64'ha000, 20);
        apb_read(dla_pkg::REG_STATUS, status);
        check_csb_data("STATUS while busy", status, 32'h1);
        apb_write(dla_pkg::REG_SRC_LO, 32'h7000);
        apb_write(dla_pkg::REG_DST_LO, 32'hc000);
        apb_write(dla_pkg::REG_CTRL, 32'h1);
        wait_done(status);
        check_csb_data("STATUS", status, 32'h2);
        check_csb_data("burst count", dla_pkg::csb_data_t'(u_mem.aw_count - base), 32'd2);
        check_burst(base, 64'ha000, 4'd15, 8'd0);
        check_burst(base + 1, 64'ha080, 4'd3, 8'd1);
        check_copy(64'h5000, 64'ha000, 20);
    endtask

    initial begin
        rst_n    <= 1'b0;
        stall_en <= 1'b0;
        psel     <= 1'b0;
        penable  <= 1'b0;
        pwrite   <= 1'b0;
        paddr    <= '0;
        pwdata   <= '0;
        repeat (16) @(posedge core_clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge core_clk);
        test_reset_regs();
        test_single_burst();
        test_stalled_copy();
        test_done_clear();
        test_start_guards();
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- test/axi_mem_model.sv
module axi_mem_model (
    input  logic               core_clk,
    input  logic               rst_n,
    input  logic               stall_en,

    input  logic               arvalid,
    output logic               arready,
    input  dla_pkg::dbb_id_t   arid,
    input  dla_pkg::dbb_len_t  arlen,
    input  dla_pkg::dbb_addr_t araddr,
    output logic               rvalid,
    input  logic               rready,
    output dla_pkg::dbb_id_t   rid,
    output logic               rlast,
    output dla_pkg::dbb_data_t rdata,
    input  logic               awvalid,
    output logic               awready,
    input  dla_pkg::dbb_id_t   awid,
    input  dla_pkg::dbb_len_t  awlen,
    input  dla_pkg::dbb_addr_t awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  dla_pkg::dbb_data_t wdata,
    input  logic               wlast,
    output logic               bvalid,
    input  logic               bready,
    output dla_pkg::dbb_id_t   bid
);

    // 64 KB window; unwritten words read as a pattern of the full address
    dla_pkg::dbb_data_t mem [8192];
    bit                 written [8192];
    dla_pkg::dbb_addr_t aw_log_addr [64];
    dla_pkg::dbb_len_t  aw_log_len [64];
    dla_pkg::dbb_id_t   aw_log_id [64];
    int                 aw_count;
    int                 w_count;
    int                 rd_left;
    integer             seed = 32'hd5c4;
    dla_pkg::dbb_addr_t rd_addr;
    dla_pkg::dbb_addr_t wr_addr;
    logic               wr_open;

    function automatic dla_pkg::dbb_data_t source_word(input dla_pkg::dbb_addr_t a);
        return {a[31:0], a[63:32]} ^ 64'h9e37_79b9_7f4a_7c15;
    endfunction

    // Ready about three cycles in four while stalls are on
    function automatic logic no_stall();
        return !stall_en || (($random(seed) & 3) != 0);
    endfunction

    always @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rlast    <= 1'b0;
            rid      <= '0;
            rdata    <= '0;
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            bid      <= '0;
            rd_left  <= 0;
            wr_open  <= 1'b0;
            aw_count <= 0;
            w_count  <= 0;
        end else begin
            //////////////////////////////////////////////////////////////////////
            // Read side, one burst at a time, a gap after every beat
            //////////////////////////////////////////////////////////////////////
            if (arvalid && arready) begin
                rd_addr <= araddr;
                rd_left <= int'(arlen) + 1;
                rid     <= arid;
                arready <= 1'b0;
            end else begin
                arready <= (rd_left == 0) && no_stall();
            end
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_addr <= rd_addr + 8;
                rd_left <= rd_left - 1;
            end else if (!rvalid && (rd_left != 0) && no_stall()) begin
                rvalid <= 1'b1;
                rlast  <= (rd_left == 1);
                rdata  <= written[rd_addr[15:3]] ? mem[rd_addr[15:3]]
                                                 : source_word(rd_addr);
            end

            //////////////////////////////////////////////////////////////////////
            // Write side, W accepted only after its AW
            //////////////////////////////////////////////////////////////////////
            if (awvalid && awready) begin
                wr_addr               <= awaddr;
                bid                   <= awid;
                awready               <= 1'b0;
                wr_open               <= 1'b1;
                aw_log_addr[aw_count] <= awaddr;
                aw_log_len[aw_count]  <= awlen;
                aw_log_id[aw_count]   <= awid;
                aw_count              <= aw_count + 1;
            end else begin
                awready <= !wr_open && !bvalid && no_stall();
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            // Strobes are always full from this master
            if (wvalid && wready) begin
                mem[wr_addr[15:3]]     <= wdata;
                written[wr_addr[15:3]] <= 1'b1;
                wr_addr                <= wr_addr + 8;
                w_count                <= w_count + 1;
                if (wlast) begin
                    wr_open <= 1'b0;
                    bvalid  <= 1'b1;
                    wready  <= 1'b0;
                end else begin
                    wready <= no_stall();
                end
            end else begin
                wready <= wr_open && no_stall();
            end
        end
    end

endmodule

//--- src/dla_wrapper.sv
module dla_wrapper (
    input  logic               core_clk,
    input  logic               rst_n,
    output logic               dla_intr,

    // DBB master
    output logic               arvalid,
    input  logic               arready,
    output dla_pkg::dbb_id_t   arid,
    output dla_pkg::dbb_len_t  arlen,
    output dla_pkg::dbb_addr_t araddr,
    input  logic               rvalid,
    output logic               rready,
    input  dla_pkg::dbb_id_t   rid,
    input  logic               rlast,
    input  dla_pkg::dbb_data_t rdata,
    output logic               awvalid,
    input  logic               awready,
    output dla_pkg::dbb_id_t   awid,
    output dla_pkg::dbb_len_t  awlen,
    output dla_pkg::dbb_addr_t awaddr,
    output logic               wvalid,
    input  logic               wready,
    output dla_pkg::dbb_data_t wdata,
    output dla_pkg::dbb_strb_t wstrb,
    output logic               wlast,
    input  logic               bvalid,
    output logic               bready,
    input  dla_pkg::dbb_id_t   bid,

    // APB configuration
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [31:0]        paddr,
    input  logic [31:0]        pwdata,
    output dla_pkg::csb_data_t prdata,
    output logic               pready
);

    // CSB bus
    logic               csb2nvdla_valid;
    logic               csb2nvdla_ready;
    dla_pkg::csb_addr_t csb2nvdla_addr;
    dla_pkg::csb_data_t csb2nvdla_wdat;
    logic               csb2nvdla_write;
    logic               csb2nvdla_nposted;
    logic               nvdla2csb_valid;
    dla_pkg::csb_data_t nvdla2csb_data;

    // Copy configuration and status
    dla_pkg::dbb_addr_t src_addr;
    dla_pkg::dbb_addr_t dst_addr;
    dla_pkg::copy_len_t copy_len;
    logic               start;
    logic               busy;
    logic               done_pulse;

    // Beat FIFO
    logic               push;
    dla_pkg::dbb_data_t push_data;
    logic               pop;
    dla_pkg::dbb_data_t pop_data;
    dla_pkg::beat_cnt_t count;

    apb2csb u_apb2csb (.*);

    csb_regs u_csb_regs (.*);

    dbb_copy_engine u_dbb_copy_engine (.*);

    beat_fifo u_beat_fifo (.*);

endmodule

//--- src/dbb_copy_engine.sv
module dbb_copy_engine (
    input  logic               core_clk,
    input  logic               rst_n,

    input  logic               start,
    input  dla_pkg::dbb_addr_t src_addr,
    input  dla_pkg::dbb_addr_t dst_addr,
    input  dla_pkg::copy_len_t copy_len,
    output logic               busy,
    output logic               done_pulse,

    output logic               push,
    output dla_pkg::dbb_data_t push_data,
    output logic               pop,
    input  dla_pkg::dbb_data_t pop_data,
    input  dla_pkg::beat_cnt_t count,

    output logic               arvalid,
    input  logic               arready,
    output dla_pkg::dbb_id_t   arid,
    output dla_pkg::dbb_len_t  arlen,
    output dla_pkg::dbb_addr_t araddr,
    input  logic               rvalid,
    output logic               rready,
    input  dla_pkg::dbb_id_t   rid,
    input  logic               rlast,
    input  dla_pkg::dbb_data_t rdata,
    output logic               awvalid,
    input  logic               awready,
    output dla_pkg::dbb_id_t   awid,
    output dla_pkg::dbb_len_t  awlen,
    output dla_pkg::dbb_addr_t awaddr,
    output logic               wvalid,
    input  logic               wready,
    output dla_pkg::dbb_data_t wdata,
    output dla_pkg::dbb_strb_t wstrb,
    output logic               wlast,
    input  logic               bvalid,
    output logic               bready,
    input  dla_pkg::dbb_id_t   bid
);

    typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_XFER, S_RESP} state_t;

    state_t             state;
    dla_pkg::copy_len_t remaining;
    dla_pkg::dbb_addr_t src_cur;
    dla_pkg::dbb_addr_t dst_cur;
    dla_pkg::dbb_addr_t burst_bytes;
    dla_pkg::dbb_id_t   burst_idx;
    dla_pkg::beat_cnt_t burst_len;
    dla_pkg::beat_cnt_t next_len;
    dla_pkg::beat_cnt_t w_cnt;
    logic               r_done;
    logic               b_fire;
    logic               last_burst;
    logic               fifo_full;

    assign next_len = (remaining > dla_pkg::copy_len_t'(dla_pkg::BURST_MAX))
                      ? dla_pkg::beat_cnt_t'(dla_pkg::BURST_MAX)
                      : dla_pkg::beat_cnt_t'(remaining);
    assign burst_bytes = dla_pkg::dbb_addr_t'(burst_len) * (dla_pkg::DBB_DATA_W / 8);
    assign last_burst  = (remaining == dla_pkg::copy_len_t'(burst_len));
    assign fifo_full   = (count == dla_pkg::beat_cnt_t'(dla_pkg::FIFO_DEPTH));
    assign busy        = (state != S_IDLE);

    //////////////////////////////////////////////////////////////////////
    // Request channels, same length and ID on both sides
    //////////////////////////////////////////////////////////////////////

    assign arid   = burst_idx;
    assign awid   = burst_idx;
    assign arlen  = dla_pkg::dbb_len_t'(burst_len - 1'b1);
    assign awlen  = arlen;
    assign araddr = src_cur;
    assign awaddr = dst_cur;

    // R beats into the FIFO, FIFO head onto W
    assign rready    = (state == S_XFER) && !r_done && !fifo_full;
    assign push      = rvalid && rready;
    assign push_data = rdata;

    assign wvalid = (state == S_XFER) && (count != '0);
    assign wdata  = pop_data;
    assign wstrb  = '1;
    assign wlast  = (w_cnt == burst_len - 1'b1);
    assign pop    = wvalid && wready;

    assign bready     = (state == S_RESP);
    assign b_fire     = bvalid && bready;
    assign done_pulse = b_fire && last_burst;

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            arvalid   <= 1'b0;
            awvalid   <= 1'b0;
            r_done    <= 1'b0;
            w_cnt     <= '0;
            remaining <= '0;
            burst_idx <= '0;
            burst_len <= '0;
        end else begin
            if (arvalid && arready) begin
                arvalid <= 1'b0;
            end
            if (awvalid && awready) begin
                awvalid <= 1'b0;
            end
            if (push && rlast) begin
                r_done <= 1'b1;
            end
            if (pop) begin
                w_cnt <= w_cnt + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (start) begin
                        remaining <= copy_len;
                        burst_idx <= '0;
                        state     <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    burst_len <= next_len;
                    arvalid   <= 1'b1;
                    awvalid   <= 1'b1;
                    r_done    <= 1'b0;
                    w_cnt     <= '0;
                    state     <= S_XFER;
                end
                S_XFER: begin
                    if (pop && wlast) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (b_fire) begin
                        remaining <= remaining - burst_len;
                        burst_idx <= burst_idx + 1'b1;
                        state     <= last_burst ? S_IDLE : S_ISSUE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Both addresses step by one burst after its B
    always_ff @(posedge core_clk) begin
        if (start) begin
            src_cur <= src_addr;
            dst_cur <= dst_addr;
        end else if (b_fire) begin
            src_cur <= src_cur + burst_bytes;
            dst_cur <= dst_cur + burst_bytes;
        end
    end

    assert property (@(posedge core_clk) disable iff (!rst_n)
        (arvalid && !arready)
        |=> arvalid && $stable(araddr) && $stable(arlen) && $stable(arid));
    assert property (@(posedge core_clk) disable iff (!rst_n)
        (awvalid && !awready)
        |=> awvalid && $stable(awaddr) && $stable(awlen) && $stable(awid));

    // Memory answers with the ID of the burst in flight
    assert property (@(posedge core_clk) disable iff (!rst_n)
        (!push || rid == burst_idx) && (!b_fire || bid == burst_idx));

endmodule

//--- src/beat_fifo.sv
module beat_fifo (
    input  logic               core_clk,
    input  logic               rst_n,
    input  logic               push,
    input  dla_pkg::dbb_data_t push_data,
    input  logic               pop,
    output dla_pkg::dbb_data_t pop_data,
    output dla_pkg::beat_cnt_t count
);

    dla_pkg::dbb_data_t                     mem [dla_pkg::FIFO_DEPTH];
    logic [$clog2(dla_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(dla_pkg::FIFO_DEPTH)-1:0] rd_ptr;

    assign pop_data = mem[rd_ptr];

    always_ff @(posedge core_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assert property (@(posedge core_clk) disable iff (!rst_n)
        push |-> (count != dla_pkg::beat_cnt_t'(dla_pkg::FIFO_DEPTH)));
    assert property (@(posedge core_clk) disable iff (!rst_n)
        pop |-> (count != '0));

endmodule

//--- src/csb_regs.sv
module csb_regs (
    input  logic               core_clk,
    input  logic               rst_n,

    input  logic               csb2nvdla_valid,
    input  dla_pkg::csb_addr_t csb2nvdla_addr,
    input  dla_pkg::csb_data_t csb2nvdla_wdat,
    input  logic               csb2nvdla_write,
    input  logic               csb2nvdla_nposted,
    output logic               csb2nvdla_ready,
    output logic               nvdla2csb_valid,
    output dla_pkg::csb_data_t nvdla2csb_data,

    output dla_pkg::dbb_addr_t src_addr,
    output dla_pkg::dbb_addr_t dst_addr,
    output dla_pkg::copy_len_t copy_len,
    output logic               start,
    input  logic               busy,
    input  logic               done_pulse,
    output logic               dla_intr
);

    logic               wr_en;
    logic               rd_en;
    logic               intr_en;
    logic               done;
    dla_pkg::csb_data_t rd_data;

    assign wr_en = csb2nvdla_valid && csb2nvdla_ready && csb2nvdla_write;
    assign rd_en = csb2nvdla_valid && csb2nvdla_ready && !csb2nvdla_write;

    assign dla_intr = done && intr_en;

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            csb2nvdla_ready <= 1'b0;
        end else begin
            csb2nvdla_ready <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Configuration registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            src_addr <= '0;
            dst_addr <= '0;
            copy_len <= '0;
            intr_en  <= 1'b0;
        end else if (wr_en) begin
            case (csb2nvdla_addr)
                dla_pkg::REG_SRC_LO:  src_addr[31:0]  <= csb2nvdla_wdat;
                dla_pkg::REG_SRC_HI:  src_addr[63:32] <= csb2nvdla_wdat;
                dla_pkg::REG_DST_LO:  dst_addr[31:0]  <= csb2nvdla_wdat;
                dla_pkg::REG_DST_HI:  dst_addr[63:32] <= csb2nvdla_wdat;
                dla_pkg::REG_LEN:     copy_len        <= csb2nvdla_wdat;
                dla_pkg::REG_INTR_EN: intr_en         <= csb2nvdla_wdat[0];
                default: ;
            endcase
        end
    end

    // Start only from idle with something to copy; done_pulse beats a clear
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= 1'b0;
            done  <= 1'b0;
        end else begin
            start <= wr_en && (csb2nvdla_addr == dla_pkg::REG_CTRL) && csb2nvdla_wdat[0]
                     && !busy && (copy_len != '0);
            if (done_pulse) begin
                done <= 1'b1;
            end else if (wr_en && (csb2nvdla_addr == dla_pkg::REG_STATUS)
                         && csb2nvdla_wdat[1]) begin
                done <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read path and responses
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (csb2nvdla_addr)
            dla_pkg::REG_STATUS:  rd_data = {30'd0, done, busy};
            dla_pkg::REG_SRC_LO:  rd_data = src_addr[31:0];
            dla_pkg::REG_SRC_HI:  rd_data = src_addr[63:32];
            dla_pkg::REG_DST_LO:  rd_data = dst_addr[31:0];
            dla_pkg::REG_DST_HI:  rd_data = dst_addr[63:32];
            dla_pkg::REG_LEN:     rd_data = copy_len;
            dla_pkg::REG_INTR_EN: rd_data = {31'd0, intr_en};
            default:              rd_data = '0;
        endcase
    end

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            nvdla2csb_valid <= 1'b0;
        end else begin
            nvdla2csb_valid <= rd_en || (wr_en && csb2nvdla_nposted);
        end
    end

    // Non-posted writes get zero data
    always_ff @(posedge core_clk) begin
        nvdla2csb_data <= rd_en ? rd_data : '0;
    end

endmodule

//--- src/apb2csb.sv
module apb2csb (
    input  logic               core_clk,
    input  logic               rst_n,

    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [31:0]        paddr,
    input  logic [31:0]        pwdata,
    output dla_pkg::csb_data_t prdata,
    output logic               pready,

    output logic               csb2nvdla_valid,
    output logic               csb2nvdla_write,
    output logic               csb2nvdla_nposted,
    output dla_pkg::csb_addr_t csb2nvdla_addr,
    output dla_pkg::csb_data_t csb2nvdla_wdat,
    input  logic               csb2nvdla_ready,
    input  logic               nvdla2csb_valid,
    input  dla_pkg::csb_data_t nvdla2csb_data
);

    logic               issued;
    dla_pkg::csb_data_t rdata_q;

    // One request per access, raised in the first access cycle
    assign csb2nvdla_valid   = psel && penable && !issued;
    assign csb2nvdla_write   = pwrite;
    assign csb2nvdla_nposted = 1'b0;
    assign csb2nvdla_addr    = paddr[17:2];
    assign csb2nvdla_wdat    = pwdata;

    // Writes are posted; reads wait for the register block answer
    assign pready = pwrite ? (csb2nvdla_valid && csb2nvdla_ready)
                           : (psel && penable && issued && nvdla2csb_valid);

    assign prdata = nvdla2csb_valid ? nvdla2csb_data : rdata_q;

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            issued <= 1'b0;
        end else if (pready) begin
            issued <= 1'b0;
        end else if (csb2nvdla_valid && csb2nvdla_ready) begin
            issued <= 1'b1;
        end
    end

    // Last read word, held after the access ends
    always_ff @(posedge core_clk) begin
        if (nvdla2csb_valid) begin
            rdata_q <= nvdla2csb_data;
        end
    end

    // Read answered in the next cycle, with no new request in between
    assert property (@(posedge core_clk) disable iff (!rst_n)
        (csb2nvdla_valid && csb2nvdla_ready && !csb2nvdla_write)
        |=> nvdla2csb_valid && !csb2nvdla_valid);

endmodule

//--- src/dla_pkg.sv
package dla_pkg;

    // DBB data path
    localparam int DBB_ADDR_W = 64;
    localparam int DBB_DATA_W = 64;

    typedef logic [DBB_ADDR_W-1:0]   dbb_addr_t;
    typedef logic [DBB_DATA_W-1:0]   dbb_data_t;
    typedef logic [DBB_DATA_W/8-1:0] dbb_strb_t;
    typedef logic [7:0]              dbb_id_t;
    typedef logic [3:0]              dbb_len_t;

    // CSB register bus
    localparam int CSB_ADDR_W = 16;

    typedef logic [CSB_ADDR_W-1:0] csb_addr_t;
    typedef logic [31:0]           csb_data_t;
    typedef logic [31:0]           copy_len_t;

    // Burst and FIFO limits
    localparam int BURST_MAX  = 16;
    localparam int FIFO_DEPTH = 16;

    typedef logic [$clog2(FIFO_DEPTH):0] beat_cnt_t;

    // Register word offsets
    localparam csb_addr_t REG_CTRL    = 16'd0;
    localparam csb_addr_t REG_STATUS  = 16'd1;
    localparam csb_addr_t REG_SRC_LO  = 16'd2;
    localparam csb_addr_t REG_SRC_HI  = 16'd3;
    localparam csb_addr_t REG_DST_LO  = 16'd4;
    localparam csb_addr_t REG_DST_HI  = 16'd5;
    localparam csb_addr_t REG_LEN     = 16'd6;
    localparam csb_addr_t REG_INTR_EN = 16'd7;

endpackage
